//--- common/adc_defines.svh
`ifndef ADC_DEFINES_SVH
`define ADC_DEFINES_SVH

// converter word and channel layout
`define ADC_W_SAMPLE 18 // bits per adc word
`define ADC_N_CHAN 8 // simultaneous channels
`define ADC_N_PER_LINE 4 // channels carried on each serial line

// bits clocked out of each line in one frame
`define ADC_RD_LENGTH (`ADC_W_SAMPLE * `ADC_N_PER_LINE)

// conversion timing, in clk_in cycles
`define ADC_MIN_T_CYCLE 85 // min clocks held in conv before next convst

// oversampling select pins
`define ADC_W_OS 2

`endif

//--- common/adc_pkg.sv
`include "adc_defines.svh"

package adc_pkg;

	////////////////////////////////////////////////////////////////////////////
	// data widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [`ADC_W_SAMPLE-1:0] adc_sample_t; // twos complement adc word
	typedef logic [$clog2(`ADC_N_CHAN)-1:0] adc_chan_t; // channel number 0..7
	typedef logic [7:0] adc_cnt_t; // per-state cycle counter

	////////////////////////////////////////////////////////////////////////////
	// state machines
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		CV_IDLE, // waiting for start command
		CV_CONVST, // convst low, one cycle
		CV_CONV // converting, waiting on min time and busy
	} conv_state_t;

	typedef enum logic [1:0] {
		RD_IDLE, // waiting for busy rise
		RD_READ, // chip select low, shifting
		RD_WAIT // frame done, waiting for busy fall
	} read_state_t;

endpackage

//--- common/sample_bus_if.sv
`timescale 1ns/100ps

// decoded words from the serial reader into the sample bank
interface sample_bus_if import adc_pkg::*; ();

	logic word_valid; // one cycle strobe, always accepted
	adc_chan_t chan_a; // channel of word_a, 0..3
	adc_chan_t chan_b; // channel of word_b, 4..7
	adc_sample_t word_a; // word from line a
	adc_sample_t word_b; // word from line b

	modport src (
		output word_valid, chan_a, chan_b, word_a, word_b
	);

	modport dst (
		input word_valid, chan_a, chan_b, word_a, word_b
	);

endinterface

//--- adc/adc_conv_seq.sv
`timescale 1ns/100ps
`include "adc_defines.svh"

module adc_conv_seq import adc_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic cstart_in, // start pulse, arms continuous conversion
	input logic busy_in, // adc conversion in progress
	output logic convst_out // convert start to adc, active low
);

	logic run; // set by start, only reset clears it
	conv_state_t cv_state; // current state
	conv_state_t cv_next; // next state
	adc_cnt_t cv_cnt; // cycles spent in current state

	////////////////////////////////////////////////////////////////////////////
	// run flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			run <= 1'b0;
		end else if (cstart_in) begin
			run <= 1'b1; // no stop command, stays armed
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sequencer fsm
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cv_next = cv_state; // hold by default
		case (cv_state)
			CV_IDLE: begin
				if (run)
					cv_next = CV_CONVST;
			end
			CV_CONVST: cv_next = CV_CONV; // single cycle pulse
			CV_CONV: begin
				if ((cv_cnt >= adc_cnt_t'(`ADC_MIN_T_CYCLE)) && !busy_in)
					cv_next = CV_CONVST; // min time met and adc done
			end
			default: cv_next = CV_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			cv_state <= CV_IDLE;
			cv_cnt <= '0;
		end else begin
			cv_state <= cv_next;
			if (cv_next != cv_state)
				cv_cnt <= '0; // restart count on each transition
			else if (cv_cnt != '1)
				cv_cnt <= cv_cnt + 1'b1; // saturate, long busy must not wrap
		end
	end

	assign convst_out = (cv_state != CV_CONVST); // low only in convst

	// a second convst pulse needs at least one conv cycle in between
	a_convst_single: assert property (@(posedge clk_in) disable iff (rst_in)
		!convst_out |=> convst_out);

endmodule

//--- adc/adc_serial_reader.sv
`timescale 1ns/100ps
`include "adc_defines.svh"

module adc_serial_reader import adc_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic busy_in, // rises at start of conversion
	input logic data_a_in, // serial data, channels 0..3
	input logic data_b_in, // serial data, channels 4..7
	output logic n_cs_out, // chip select to adc, active low
	output logic sclk_out, // serial clock to adc, idle high
	sample_bus_if.src bus
);

	read_state_t rd_state; // current state
	read_state_t rd_next; // next state
	adc_cnt_t rd_cnt; // bit counter, counts in read only
	logic cs_d; // chip select delayed to match capture flops
	logic data_a_q; // capture flop, line a
	logic data_b_q; // capture flop, line b
	adc_sample_t sreg_a; // shift register, line a
	adc_sample_t sreg_b; // shift register, line b
	logic word_end; // shift register completes a word this edge
	logic word_end_q; // word ready in shift registers
	adc_chan_t chan_nxt; // line a channel of the next word

	////////////////////////////////////////////////////////////////////////////
	// read fsm
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			RD_IDLE: begin
				if (busy_in)
					rd_next = RD_READ; // previous result now valid
			end
			RD_READ: begin
				if (rd_cnt == adc_cnt_t'(`ADC_RD_LENGTH))
					rd_next = RD_WAIT; // last bit shifted
			end
			RD_WAIT: begin
				if (!busy_in)
					rd_next = RD_IDLE;
			end
			default: rd_next = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			rd_state <= RD_IDLE;
			rd_cnt <= '0;
		end else begin
			rd_state <= rd_next;
			if (rd_next != rd_state)
				rd_cnt <= '0;
			else if (rd_state == RD_READ)
				rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// registered chip select, low for exactly one frame of bits
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			n_cs_out <= 1'b1;
			cs_d <= 1'b0;
		end else begin
			n_cs_out <= !((rd_state == RD_IDLE && busy_in) ||
				(rd_state == RD_READ && rd_cnt < adc_cnt_t'(`ADC_RD_LENGTH - 1)));
			cs_d <= !n_cs_out; // bit k sits in capture flop one edge later
		end
	end

	assign sclk_out = clk_in | n_cs_out; // gated copy, parked high outside frame

	////////////////////////////////////////////////////////////////////////////
	// capture and shift
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		data_a_q <= data_a_in; // sampled on rising clk_in
		data_b_q <= data_b_in;
		if (cs_d) begin
			sreg_a <= {sreg_a[`ADC_W_SAMPLE-2:0], data_a_q}; // msb first
			sreg_b <= {sreg_b[`ADC_W_SAMPLE-2:0], data_b_q};
		end
	end

	// word boundaries at bit counts 18, 36, 54, 72
	always_comb begin
		word_end = 1'b0;
		for (int i = 1; i <= `ADC_N_PER_LINE; i++) begin
			if (rd_cnt == adc_cnt_t'(i * `ADC_W_SAMPLE))
				word_end = 1'b1;
		end
		word_end = word_end && (rd_state == RD_READ);
	end

	////////////////////////////////////////////////////////////////////////////
	// word output
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			word_end_q <= 1'b0;
			bus.word_valid <= 1'b0;
			bus.chan_a <= '0;
			bus.chan_b <= '0;
			chan_nxt <= '0;
		end else begin
			word_end_q <= word_end;
			bus.word_valid <= word_end_q;
			if (rd_state == RD_IDLE) begin
				chan_nxt <= '0; // each frame starts at channel 0
			end else if (word_end_q) begin
				bus.chan_a <= chan_nxt;
				bus.chan_b <= chan_nxt + adc_chan_t'(`ADC_N_PER_LINE); // line b offset
				chan_nxt <= chan_nxt + 1'b1;
			end
		end
	end

	// hold the word while the shift registers move on
	always_ff @(posedge clk_in) begin
		if (word_end_q) begin
			bus.word_a <= sreg_a;
			bus.word_b <= sreg_b;
		end
	end

	// a frame only opens once the adc has started converting
	a_cs_on_busy: assert property (@(posedge clk_in) disable iff (rst_in)
		$fell(n_cs_out) |-> $past(rd_state == RD_IDLE && busy_in));

endmodule

//--- design/sample_bank.sv
`timescale 1ns/100ps
`include "adc_defines.svh"

module sample_bank import adc_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input adc_chan_t chan_sel_in, // read port channel select
	output adc_sample_t sample_out, // selected sample, one cycle later
	output logic frame_out, // pulse after the last word of a frame
	sample_bus_if.dst bus
);

	adc_sample_t bank [`ADC_N_CHAN]; // latest word per channel
	logic [$clog2(`ADC_N_PER_LINE)-1:0] word_cnt; // words seen in current frame

	////////////////////////////////////////////////////////////////////////////
	// sample registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			for (int i = 0; i < `ADC_N_CHAN; i++)
				bank[i] <= '0; // samples read back as zero after reset
		end else if (bus.word_valid) begin
			bank[bus.chan_a] <= bus.word_a; // lower half
			bank[bus.chan_b] <= bus.word_b; // upper half
		end
	end

	// frame marker
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			word_cnt <= '0;
			frame_out <= 1'b0;
		end else begin
			frame_out <= bus.word_valid && (&word_cnt); // fourth word written
			if (bus.word_valid)
				word_cnt <= word_cnt + 1'b1; // wraps to 0 for next frame
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rst_in)
			sample_out <= '0;
		else
			sample_out <= bank[chan_sel_in];
	end

	// both lines must deliver the same slot of the frame together
	a_chan_pair: assert property (@(posedge clk_in) disable iff (rst_in)
		bus.word_valid |-> (bus.chan_b == adc_chan_t'(bus.chan_a + `ADC_N_PER_LINE)));

endmodule

//--- design/adc_subsys_top.sv
`timescale 1ns/100ps
`include "adc_defines.svh"

module adc_subsys_top import adc_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic cstart_in, // start continuous conversion
	input logic [`ADC_W_OS-1:0] os_in, // oversampling select
	input logic busy_in, // from adc
	input logic data_a_in, // from adc, line a
	input logic data_b_in, // from adc, line b
	input adc_chan_t chan_sel_in, // sample read select
	output logic [`ADC_W_OS-1:0] os_out, // to adc os pins
	output logic reset_out, // to adc reset pin
	output logic convst_out, // to adc
	output logic n_cs_out, // to adc
	output logic sclk_out, // to adc
	output adc_sample_t sample_out, // selected channel sample
	output logic frame_out // new frame stored
);

	sample_bus_if sbus (); // reader to bank words

	assign os_out = os_in; // pass through
	assign reset_out = rst_in; // adc reset follows system reset

	adc_conv_seq u_conv_seq (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.cstart_in(cstart_in),
		.busy_in(busy_in),
		.convst_out(convst_out)
	);

	adc_serial_reader u_serial_reader (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.busy_in(busy_in),
		.data_a_in(data_a_in),
		.data_b_in(data_b_in),
		.n_cs_out(n_cs_out),
		.sclk_out(sclk_out),
		.bus(sbus.src)
	);

	sample_bank u_sample_bank (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.chan_sel_in(chan_sel_in),
		.sample_out(sample_out),
		.frame_out(frame_out),
		.bus(sbus.dst)
	);

endmodule

//--- testbench/ad7608_model.sv
`timescale 1ns/100ps
`include "adc_defines.svh"

// behavioral eight channel adc, busy timing and two line serial readout
module ad7608_model import adc_pkg::*; (
	input logic clk_in,
	input logic adc_reset, // reset pin, aborts conversion
	input logic convst, // convert start, active low
	input logic n_cs, // chip select, active low
	input logic sclk, // serial clock, idle high
	output logic busy, // conversion in progress
	output logic data_a, // channels 0..3, msb first
	output logic data_b // channels 4..7, msb first
);

	localparam int CONV_MIN = 30; // shortest conversion, clk cycles
	localparam int CONV_SPAN = 91; // gives 30..120

	logic [31:0] lcg_state = 32'he4f3_342b; // fixed seed
	int busy_left; // cycles of conversion still to go
	logic [`ADC_RD_LENGTH-1:0] shift_a; // frame image, line a
	logic [`ADC_RD_LENGTH-1:0] shift_b; // frame image, line b
	adc_sample_t smp_q[$]; // drawn samples in channel order, popped by the testbench

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	initial begin
		busy = 1'b0;
		data_a = 1'b0;
		data_b = 1'b0;
		busy_left = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// conversion timing
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk_in) begin
		if (adc_reset) begin
			busy_left = 0;
			smp_q.delete(); // aborted frame is never stored
			#10 busy = 1'b0;
		end else if (busy_left > 0) begin
			busy_left = busy_left - 1;
			if (busy_left == 0)
				#10 busy = 1'b0; // conversion done
		end else if (!convst) begin
			busy_left = CONV_MIN + int'(lcg_next() >> 8) % CONV_SPAN; // random conv time
			#10 busy = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// serial readout
	////////////////////////////////////////////////////////////////////////////

	always @(negedge n_cs) begin
		adc_sample_t smp;
		if (!adc_reset) begin
			for (int ch = 0; ch < `ADC_N_CHAN; ch++) begin
				smp = adc_sample_t'(lcg_next() >> 14); // top 18 bits
				smp_q.push_back(smp);
				if (ch < `ADC_N_PER_LINE)
					shift_a = {shift_a[`ADC_RD_LENGTH-`ADC_W_SAMPLE-1:0], smp};
				else
					shift_b = {shift_b[`ADC_RD_LENGTH-`ADC_W_SAMPLE-1:0], smp};
			end
			data_a = shift_a[`ADC_RD_LENGTH-1]; // first bit out before any sclk edge
			data_b = shift_b[`ADC_RD_LENGTH-1];
		end
	end

	// next bit shortly after each rising sclk
	always @(posedge sclk) begin
		#5;
		shift_a = shift_a << 1;
		shift_b = shift_b << 1;
		data_a = shift_a[`ADC_RD_LENGTH-1];
		data_b = shift_b[`ADC_RD_LENGTH-1];
	end

endmodule

//--- testbench/tb_adc_subsys.sv
`timescale 1ns/100ps
`include "adc_defines.svh"

module tb_adc_subsys import adc_pkg::*;;

	localparam int RUN_FRAMES = 12; // frames checked in the first run
	localparam int FRAME_CYCLES = 122; // longest conversion plus convst turnaround
	localparam int WD_CYCLES = 20 * FRAME_CYCLES + 600; // 20 frames plus idle checks
	localparam int FRAME_LATENCY = 76; // busy rise to frame_out
	localparam int MIN_CONVST_GAP = `ADC_MIN_T_CYCLE + 2;

	logic clk_in;
	logic rst_in;
	logic cstart_in;
	logic [`ADC_W_OS-1:0] os_in;
	adc_chan_t chan_sel_in;
	logic busy; // model to dut
	logic data_a;
	logic data_b;
	logic [`ADC_W_OS-1:0] os_out;
	logic reset_out;
	logic convst_out;
	logic n_cs_out;
	logic sclk_out;
	adc_sample_t sample_out;
	logic frame_out;

	int err_cnt = 0;
	int chk_cnt = 0;
	int cyc = 0; // negedge count
	int n_busy = 0; // busy periods seen since reset
	int n_frame = 0; // frame_out pulses since reset
	int busy_rise_cyc; // cycle of latest busy rise
	int busy_run; // cycles busy has been high
	int last_busy_len; // length of latest finished busy period
	int cs_run; // cycles n_cs has been low
	int last_cv_cyc; // cycle of previous convst pulse
	logic cv_seen; // a convst pulse seen since reset
	logic convst_prev;
	logic busy_prev;

	adc_subsys_top dut0 (
		.clk_in(clk_in), .rst_in(rst_in), .cstart_in(cstart_in), .os_in(os_in),
		.busy_in(busy), .data_a_in(data_a), .data_b_in(data_b), .chan_sel_in(chan_sel_in),
		.os_out(os_out), .reset_out(reset_out), .convst_out(convst_out), .n_cs_out(n_cs_out),
		.sclk_out(sclk_out), .sample_out(sample_out), .frame_out(frame_out)
	);

	ad7608_model adc0 (
		.clk_in(clk_in), .adc_reset(reset_out), .convst(convst_out), .n_cs(n_cs_out),
		.sclk(sclk_out), .busy(busy), .data_a(data_a), .data_b(data_b)
	);

	initial clk_in = 1'b0;
	always #50 clk_in = ~clk_in; // 100 ns period

	task automatic check_equal(input string what, input int exp_v, input int act_v);
		chk_cnt++;
		if (exp_v != act_v) begin
			err_cnt++;
			$display("ERROR %s: expected %0d, actual %0d at %0t", what, exp_v, act_v, $time);
		end
	endtask

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("%s at %0t", msg, $time);
	endtask

	task automatic apply_reset(input int n);
		@(posedge clk_in);
		#10 rst_in = 1'b1;
		repeat (n) @(posedge clk_in);
		#10 rst_in = 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk_in);
		#10 cstart_in = 1'b1;
		@(posedge clk_in);
		#10 cstart_in = 1'b0;
	endtask

	task automatic check_idle(input string what, input int n);
		repeat (n) begin
			@(negedge clk_in);
			check_equal({what, " convst"}, 1, int'(convst_out));
			check_equal({what, " n_cs"}, 1, int'(n_cs_out));
			check_equal({what, " sclk"}, 1, int'(sclk_out));
			check_equal({what, " frame"}, 0, int'(frame_out));
		end
	endtask

	task automatic wait_frame();
		do @(negedge clk_in); while (frame_out !== 1'b1);
	endtask

	// select each channel and read it back one cycle later
	task automatic sweep_samples(input string what, input bit expect_zero);
		adc_sample_t exp_smp [`ADC_N_CHAN];
		if (!expect_zero && adc0.smp_q.size() < `ADC_N_CHAN) begin
			flag_error("model holds fewer than eight samples for this frame");
			return;
		end
		for (int ch = 0; ch < `ADC_N_CHAN; ch++)
			exp_smp[ch] = expect_zero ? adc_sample_t'(0) : adc0.smp_q.pop_front();
		for (int ch = 0; ch < `ADC_N_CHAN; ch++) begin
			@(posedge clk_in);
			#10 chan_sel_in = adc_chan_t'(ch);
			@(posedge clk_in);
			@(negedge clk_in);
			check_equal($sformatf("%s ch%0d", what, ch), int'(exp_smp[ch]), int'(sample_out));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// protocol monitor
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_in) begin
		int gap;
		cyc++;
		if (rst_in) begin
			check_equal("adc reset pin in reset", 1, int'(reset_out));
			n_busy = 0;
			n_frame = 0;
			busy_run = 0;
			last_busy_len = 0;
			cs_run = 0;
			cv_seen = 1'b0;
			convst_prev = 1'b1;
			busy_prev = 1'b0;
		end else begin
			if (!convst_out) begin
				if (!convst_prev)
					flag_error("convst held low for more than one cycle");
				if (cv_seen) begin
					gap = cyc - last_cv_cyc;
					if (gap < MIN_CONVST_GAP)
						flag_error($sformatf("convst pulses only %0d cycles apart", gap));
					if (gap < last_busy_len + 2)
						flag_error($sformatf("convst %0d cycles after the last, busy was %0d",
							gap, last_busy_len));
				end
				cv_seen = 1'b1;
				last_cv_cyc = cyc;
			end
			if (busy) begin
				if (!busy_prev) begin
					n_busy++; // new conversion
					busy_rise_cyc = cyc;
				end
				busy_run++;
			end else if (busy_prev) begin
				last_busy_len = busy_run;
				busy_run = 0;
			end
			if (!n_cs_out) begin
				cs_run++;
			end else if (cs_run != 0) begin
				check_equal("n_cs low cycles", `ADC_RD_LENGTH, cs_run);
				cs_run = 0;
			end
			check_equal("sclk gated by n_cs", int'(n_cs_out), int'(sclk_out)); // clk low here
			if (frame_out) begin
				n_frame++;
				check_equal("busy to frame latency", FRAME_LATENCY, cyc - busy_rise_cyc);
				check_equal("frames vs busy periods", n_busy, n_frame);
			end
			convst_prev = convst_out;
			busy_prev = busy;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rst_in = 1'b1;
		cstart_in = 1'b0;
		os_in = 2'b10;
		chan_sel_in = '0;
		repeat (5) @(posedge clk_in);
		#10 rst_in = 1'b0;

		check_idle("idle after reset", 20); // nothing moves without start
		for (int v = 0; v < (1 << `ADC_W_OS); v++) begin
			@(posedge clk_in);
			#10 os_in = v[`ADC_W_OS-1:0]; // walk every os code
			@(negedge clk_in);
			check_equal("os pass-through", v, int'(os_out));
		end
		check_equal("adc reset pin", 0, int'(reset_out));
		sweep_samples("reset samples", 1'b1);

		pulse_start(); // continuous conversion from here
		repeat (RUN_FRAMES) begin
			wait_frame();
			sweep_samples("frame samples", 1'b0);
		end

		do @(negedge clk_in); while (n_cs_out); // into a frame
		repeat (30) @(posedge clk_in);
		apply_reset(5);
		check_idle("idle after mid-run reset", 200);
		sweep_samples("cleared samples", 1'b1);

		pulse_start(); // restart needs a new start pulse
		wait_frame();
		sweep_samples("restart samples", 1'b0);

		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WD_CYCLES) @(posedge clk_in);
		$display("timeout: run did not finish within %0d cycles", WD_CYCLES);
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		$display("tests failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+common
common/adc_pkg.sv
common/sample_bus_if.sv
adc/adc_conv_seq.sv
adc/adc_serial_reader.sv
design/sample_bank.sv
design/adc_subsys_top.sv
testbench/ad7608_model.sv
testbench/tb_adc_subsys.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_subsys \
		-f vlog.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
